/* build.f */
+incdir+hw
hw/rvDecodePkg.sv
hw/stageLink.sv
hw/creditCounter.sv
hw/ctrlDecodeStage.sv
hw/immGenStage.sv
hw/rvDecodeTop.sv
test/decodeChecker.sv
test/tbRvDecode.sv

/* Bender.yml */
package:
  name: rv_decode

sources:
  - include_dirs:
      - hw
    files:
      - hw/rvDecodePkg.sv
      - hw/stageLink.sv
      - hw/creditCounter.sv
      - hw/ctrlDecodeStage.sv
      - hw/immGenStage.sv
      - hw/rvDecodeTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/decodeChecker.sv
      - test/tbRvDecode.sv

/* test/tbRvDecode.sv */
/*
  Testbench for rvDecodeTop: random producer with credit tracking and a
  consumer that frees its slots after 0 to 6 cycles.
  Checking is done in decodeChecker; the run is bounded by a watchdog.
*/
`timescale 1ns/1ps
`include "rvDecode_cfg.svh"

module tbRvDecode
  import rvDecodePkg::*;
();
  localparam int numItems      = 300;
  localparam int timeoutCycles = numItems * 20 + 200;

  logic                 clk;
  logic                 rstN;
  logic                 inValid;
  logic [`RVD_ILEN-1:0] instr;
  logic                 inCredit;
  logic                 outValid;
  logic                 outCredit;
  logic                 outAluSrcA;
  aluSrcB_e             outAluSrcB;
  aluOp_e               outAluOp;
  branch_e              outBranch;
  memOp_e               outMemOp;
  logic                 outMemToReg;
  logic                 outMemWen;
  logic                 outRegWen;
  logic                 outIllegal;
  logic [`RVD_XLEN-1:0] outImm;
  logic                 runEnd;
  logic                 endDone;
  int                   checked;
  int                   passed;
  int                   errors;

  integer seed = 13;
  int     prodCredits;     // producer's view of stage 1's slot
  int     sent;
  int     cycle;
  int     releaseQ[$];     // cycle at which each held slot is freed

  rvDecodeTop i_dut (.*);

  decodeChecker i_chk (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // word-form func3: addw, sllw, srlw/sraw
  function automatic logic [2:0] pickW(input logic [1:0] r);
    return (r == 2'd0) ? 3'b000 : (r == 2'd1) ? 3'b001 : 3'b101;
  endfunction

  function automatic logic [`RVD_ILEN-1:0] randInstr();
    logic [31:0] r;
    logic [6:0]  f7;
    int          kind;
    r    = $random(seed);
    kind = $unsigned($random(seed)) % 13;
    f7   = r[30] ? 7'b0100000 : 7'b0000000;  // bit 30 picks sub / sra
    case (kind)
      0:  return {r[31:7], 7'b0110111};
      1:  return {r[31:7], 7'b0010111};
      2:  return {r[31:7], 7'b1101111};
      3:  return {r[31:15], 3'b000, r[11:7], 7'b1100111};
      4:  return {r[31:7], 7'b0010011};
      5:  return {f7, r[24:12], r[11:7], 7'b0110011};
      6:  return {r[31:15], r[14] | r[13], r[13:12], r[11:7], 7'b1100011};  // skips 01x
      7:  return {r[31:15], (r[14:12] == 3'b111) ? 3'b110 : r[14:12], r[11:7], 7'b0000011};
      8:  return {r[31:15], 1'b0, r[13:12], r[11:7], 7'b0100011};
      9:  return {r[31:15], pickW(r[13:12]), r[11:7], 7'b0011011};
      10: return {f7, r[24:15], pickW(r[13:12]), r[11:7], 7'b0111011};
      default: begin                     // illegal encodings
        case (r[1:0])
          2'd0: return {r[31:7], 7'b1110011};                           // SYSTEM
          2'd1: return {7'b0000001, r[24:7], r[3] ? 7'b0111011 : 7'b0110011};
          2'd2: return {r[31:7], r[5] ? 7'b0001111 : 7'b1010011};       // fence, fp
          default: begin
            if (r[6]) return {r[31:15], 1'b0, 1'b1, r[12], r[11:7], 7'b1100011};
            else if (r[5]) return {r[31:15], 3'b111, r[11:7], 7'b0000011};
            else return {r[31:15], 1'b1, r[13:12], r[11:7], 7'b0100011};
          end
        endcase
      end
    endcase
  endfunction

  // producer and consumer share one process so the random stream stays ordered
  always @(posedge clk) begin
    if (!rstN) begin
      prodCredits = `RVD_IN_CREDITS;
      sent        = 0;
      cycle       = 0;
      releaseQ.delete();
      inValid   <= 1'b0;
      outCredit <= 1'b0;
    end else begin
      cycle++;
      if (inCredit) prodCredits++;              // slot freed this edge
      if (prodCredits > 0 && sent < numItems && ($random(seed) & 3) != 0) begin
        instr   <= randInstr();
        inValid <= 1'b1;
        prodCredits--;
        sent++;
      end else begin
        inValid <= 1'b0;
      end
      if (outValid) releaseQ.push_back(cycle + ($unsigned($random(seed)) % 7));
      if (releaseQ.size() > 0 && releaseQ[0] <= cycle) begin
        void'(releaseQ.pop_front());
        outCredit <= 1'b1;
      end else begin
        outCredit <= 1'b0;
      end
    end
  end

  initial begin
    rstN      = 1'b0;
    inValid   = 1'b0;
    instr     = '0;
    outCredit = 1'b0;
    runEnd    = 1'b0;
    repeat (16) @(posedge clk);
    rstN <= 1'b1;
    wait (checked == numItems);
    repeat (10) @(posedge clk);   // catch stray outputs and late credits
    runEnd <= 1'b1;
    wait (endDone);
    $display("%0d tests run, %0d passed, %0d errors", checked, passed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (timeoutCycles) @(posedge clk);
    $display("watchdog: run still busy after %0d cycles, %0d of %0d items checked",
             timeoutCycles, checked, numItems);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* test/decodeChecker.sv */
/*
  Scoreboard for rvDecodeTop, sampled on the rising clock edge.
  Accepted instructions are queued and every output item is compared, in order,
  with a reference decode built from the control-code tables.
  Illegal items are only checked for illegal and the cleared enables.
*/
`timescale 1ns/1ps
`include "rvDecode_cfg.svh"

module decodeChecker
  import rvDecodePkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 inValid,
  input  logic [`RVD_ILEN-1:0] instr,
  input  logic                 inCredit,
  input  logic                 outValid,
  input  logic                 outCredit,
  input  logic                 outAluSrcA,
  input  aluSrcB_e             outAluSrcB,
  input  aluOp_e               outAluOp,
  input  branch_e              outBranch,
  input  memOp_e               outMemOp,
  input  logic                 outMemToReg,
  input  logic                 outMemWen,
  input  logic                 outRegWen,
  input  logic                 outIllegal,
  input  logic [`RVD_XLEN-1:0] outImm,
  input  logic                 runEnd,     // producer done and pipeline drained
  output int                   checked,
  output int                   passed,
  output int                   errors,
  output logic                 endDone
);
  logic [`RVD_ILEN-1:0] expQ[$];  // accepted but not yet out
  int accepted;
  int creditPulses;
  int outCount;
  int creditsBack;

  initial begin
    checked      = 0;
    passed       = 0;
    errors       = 0;
    endDone      = 1'b0;
    accepted     = 0;
    creditPulses = 0;
    outCount     = 0;
    creditsBack  = 0;
  end

  // immediate placed bit by bit from the ISA formats, sign bit at msb
  function automatic logic [`RVD_XLEN-1:0] expectImm(input logic [`RVD_ILEN-1:0] ins,
                                                     input extOp_e fmt);
    logic [31:0]          raw;
    logic [`RVD_XLEN-1:0] v;
    int                   msb;
    int                   i;
    raw = '0;
    msb = 11;
    case (fmt)
      extI: raw[11:0] = ins[31:20];
      extU: begin
        raw[31:12] = ins[31:12];
        msb        = 31;
      end
      extS: begin
        raw[11:5] = ins[31:25];
        raw[4:0]  = ins[11:7];
      end
      extB: begin
        raw[12]   = ins[31];
        raw[11]   = ins[7];
        raw[10:5] = ins[30:25];
        raw[4:1]  = ins[11:8];
        msb       = 12;
      end
      extJ: begin
        raw[20]    = ins[31];
        raw[19:12] = ins[19:12];
        raw[11]    = ins[20];
        raw[10:1]  = ins[30:21];
        msb        = 20;
      end
      default: raw = '0;           // R has no immediate
    endcase
    for (i = 0; i < `RVD_XLEN; i++) begin
      v[i] = raw[(i <= msb) ? i : msb];
    end
    return v;
  endfunction

  // reference decode from the opcode map and code tables
  function automatic decodedItem_t expectDecode(input logic [`RVD_ILEN-1:0] ins);
    decodedItem_t e;
    logic [2:0]   f3;
    logic         regForm;
    logic         wForm;
    logic         alt;
    f3      = ins[14:12];
    regForm = ins[5];                // OP / OP-32 vs immediate forms
    wForm   = ins[3];                // 32-bit word forms
    e.ctrl  = '{aluSrcA: 1'b1, aluSrcB: srcBRs2, aluOp: aluAdd, extOp: extR,
                branch: brNone, memOp: memWord, memToReg: 1'b0, memWen: 1'b0,
                regWen: 1'b0, illegal: 1'b0};
    e.imm   = '0;
    case (ins[6:0])
      7'b0110111: begin            // lui
        e.ctrl.aluSrcB = srcBImm;
        e.ctrl.aluOp   = aluCopyB;
        e.ctrl.regWen  = 1'b1;
        e.imm = expectImm(ins, extU);
      end
      7'b0010111: begin            // auipc
        e.ctrl.aluSrcA = 1'b0;
        e.ctrl.aluSrcB = srcBImm;
        e.ctrl.regWen  = 1'b1;
        e.imm = expectImm(ins, extU);
      end
      7'b1101111, 7'b1100111: begin  // jal, jalr
        e.ctrl.aluSrcA = 1'b0;
        e.ctrl.aluSrcB = srcBFour;
        e.ctrl.regWen  = 1'b1;
        e.ctrl.branch  = ins[3] ? brJal : brJalr;
        e.imm = expectImm(ins, ins[3] ? extJ : extI);
      end
      7'b0010011, 7'b0110011, 7'b0011011, 7'b0111011: begin
        alt = ins[30] && (f3 == 3'b101 || (regForm && f3 == 3'b000));
        e.ctrl.aluOp   = aluOp_e'({wForm, alt, f3});  // code = f3 + 8*alt + 16*w
        e.ctrl.aluSrcB = regForm ? srcBRs2 : srcBImm;
        e.ctrl.regWen  = 1'b1;
        e.ctrl.illegal = regForm && ins[31:25] == 7'b0000001;  // M extension
        if (!regForm) e.imm = expectImm(ins, extI);
      end
      7'b1100011: begin            // branches
        e.ctrl.illegal = (f3[2:1] == 2'b01);
        e.ctrl.aluOp   = (f3 >= 3'b110) ? aluSltu : aluSlt;
        if (f3[2]) e.ctrl.branch = f3[0] ? brGe : brLt;
        else       e.ctrl.branch = f3[0] ? brNe : brEq;
        e.imm = expectImm(ins, extB);
      end
      7'b0000011: begin            // loads
        e.ctrl.illegal  = (f3 == 3'b111);
        e.ctrl.aluSrcB  = srcBImm;
        e.ctrl.memToReg = 1'b1;
        e.ctrl.regWen   = 1'b1;
        case (f3)
          3'd0: e.ctrl.memOp = memByte;
          3'd1: e.ctrl.memOp = memHalf;
          3'd2: e.ctrl.memOp = memWord;
          3'd3: e.ctrl.memOp = memDouble;
          3'd4: e.ctrl.memOp = memByteU;
          3'd5: e.ctrl.memOp = memHalfU;
          default: e.ctrl.memOp = memWordU;
        endcase
        e.imm = expectImm(ins, extI);
      end
      7'b0100011: begin            // stores
        e.ctrl.illegal = f3[2];
        e.ctrl.aluSrcB = srcBImm;
        e.ctrl.memWen  = 1'b1;
        case (f3[1:0])
          2'd0: e.ctrl.memOp = memByte;
          2'd1: e.ctrl.memOp = memHalf;
          2'd2: e.ctrl.memOp = memWord;
          default: e.ctrl.memOp = memDouble;
        endcase
        e.imm = expectImm(ins, extS);
      end
      default: e.ctrl.illegal = 1'b1;  // SYSTEM and unknown
    endcase
    if (e.ctrl.illegal) begin
      e.ctrl.regWen   = 1'b0;
      e.ctrl.memWen   = 1'b0;
      e.ctrl.memToReg = 1'b0;
    end
    return e;
  endfunction

  function automatic string className(input logic [`RVD_ILEN-1:0] ins);
    case (ins[6:0])
      7'b0110111: return "lui";
      7'b0010111: return "auipc";
      7'b1101111: return "jal";
      7'b1100111: return "jalr";
      7'b0010011: return "opImm";
      7'b0110011: return "op";
      7'b0011011: return "opImm32";
      7'b0111011: return "op32";
      7'b1100011: return "branch";
      7'b0000011: return "load";
      7'b0100011: return "store";
      7'b1110011: return "system";
      default:    return "unknown";
    endcase
  endfunction

  task automatic checkField(input string name, input string field,
                            input logic [63:0] expVal, input logic [63:0] actVal,
                            inout bit ok);
    if (actVal !== expVal) begin
      $display("[ERROR] %s %s expected 0x%0h actual 0x%0h", name, field, expVal, actVal);
      ok = 1'b0;
    end
  endtask

  task automatic compareItem(input logic [`RVD_ILEN-1:0] ins);
    decodedItem_t e;
    string        name;
    bit           ok;
    e    = expectDecode(ins);
    name = $sformatf("item%0d_%s%s", checked, className(ins),
                     e.ctrl.illegal ? "_illegal" : "");
    ok   = 1'b1;
    checkField(name, "illegal", e.ctrl.illegal, outIllegal, ok);
    checkField(name, "regWen", e.ctrl.regWen, outRegWen, ok);
    checkField(name, "memWen", e.ctrl.memWen, outMemWen, ok);
    checkField(name, "memToReg", e.ctrl.memToReg, outMemToReg, ok);
    if (!e.ctrl.illegal) begin
      checkField(name, "aluSrcA", e.ctrl.aluSrcA, outAluSrcA, ok);
      checkField(name, "aluSrcB", e.ctrl.aluSrcB, outAluSrcB, ok);
      checkField(name, "aluOp", e.ctrl.aluOp, outAluOp, ok);
      checkField(name, "branch", e.ctrl.branch, outBranch, ok);
      checkField(name, "imm", e.imm, outImm, ok);
      if (e.ctrl.memWen || e.ctrl.memToReg)        // memOp only matters for memory ops
        checkField(name, "memOp", e.ctrl.memOp, outMemOp, ok);
    end
    checked++;
    if (ok) begin
      passed++;
      $display("ok   %s instr=%08h", name, ins);
    end else begin
      errors++;
      $display("FAIL %s instr=%08h", name, ins);
    end
  endtask

  always @(posedge clk) begin
    if (rstN) begin
      if (outValid) begin
        outCount++;
        if (outCount > creditsBack + `RVD_OUT_CREDITS) begin  // credits seen before this edge
          $display("outValid sent item %0d with only %0d credits returned", outCount,
                   creditsBack);
          errors++;
        end
        if (expQ.size() == 0) begin
          $display("outValid came out with no accepted instruction waiting");
          errors++;
        end else begin
          compareItem(expQ.pop_front());
        end
      end
      if (outCredit) creditsBack++;
      if (inValid) begin
        expQ.push_back(instr);
        accepted++;
      end
      if (inCredit) creditPulses++;
      if (runEnd && !endDone) begin
        if (expQ.size() != 0) begin
          $display("%0d accepted instructions never came out", expQ.size());
          errors++;
        end
        if (creditPulses != accepted) begin
          $display("inCredit pulsed %0d times for %0d accepted instructions",
                   creditPulses, accepted);
          errors++;
        end
        endDone <= 1'b1;
      end
    end
  end

endmodule

/* hw/rvDecodeTop.sv */
/*
  Two-stage credit-controlled RV64I decoder.
  Least latency is two cycles from inValid to outValid.
  Producer starts with RVD_IN_CREDITS, consumer grants RVD_OUT_CREDITS.
*/
`timescale 1ns/1ps
`include "rvDecode_cfg.svh"

module rvDecodeTop
  import rvDecodePkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 inValid,
  input  logic [`RVD_ILEN-1:0] instr,
  output logic                 inCredit,
  output logic                 outValid,
  input  logic                 outCredit,
  output logic                 outAluSrcA,
  output aluSrcB_e             outAluSrcB,
  output aluOp_e               outAluOp,
  output branch_e              outBranch,
  output memOp_e               outMemOp,
  output logic                 outMemToReg,
  output logic                 outMemWen,
  output logic                 outRegWen,
  output logic                 outIllegal,
  output logic [`RVD_XLEN-1:0] outImm
);
  stageLink #(.payload_t(ctrlItem_t))    ctrlLink (.clk(clk), .rstN(rstN));
  stageLink #(.payload_t(decodedItem_t)) outLink  (.clk(clk), .rstN(rstN));

  ctrlDecodeStage uCtrlDecode (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .instr    (instr),
    .inCredit (inCredit),
    .down     (ctrlLink.tx)
  );

  immGenStage uImmGen (
    .clk  (clk),
    .rstN (rstN),
    .up   (ctrlLink.rx),
    .down (outLink.tx)
  );

  // output link flattened to plain ports
  assign outValid       = outLink.valid;
  assign outLink.credit = outCredit;
  assign outAluSrcA     = outLink.data.ctrl.aluSrcA;
  assign outAluSrcB     = outLink.data.ctrl.aluSrcB;
  assign outAluOp       = outLink.data.ctrl.aluOp;
  assign outBranch      = outLink.data.ctrl.branch;
  assign outMemOp       = outLink.data.ctrl.memOp;
  assign outMemToReg    = outLink.data.ctrl.memToReg;
  assign outMemWen      = outLink.data.ctrl.memWen;
  assign outRegWen      = outLink.data.ctrl.regWen;
  assign outIllegal     = outLink.data.ctrl.illegal;
  assign outImm         = outLink.data.imm;

endmodule

/* hw/immGenStage.sv */
/*
  Stage 2: builds the sign-extended immediate named by extOp.
  One-entry slot; sends only while the consumer holds a free slot.
  R format and unused extOp codes give a zero immediate.
*/
`timescale 1ns/1ps
`include "rvDecode_cfg.svh"

module immGenStage
  import rvDecodePkg::*;
(
  input  logic clk,
  input  logic rstN,
  stageLink.rx up,
  stageLink.tx down
);
  logic [`RVD_ILEN-1:0] ins;
  logic [`RVD_XLEN-1:0] imm;
  logic                 slotFull;
  decodedItem_t         slotItem;
  logic                 downAvail;
  logic                 sendNow;

  assign ins = up.data.instr;

  always_comb begin
    case (up.data.ctrl.extOp)
      extI:    imm = {{(`RVD_XLEN-12){ins[31]}}, ins[31:20]};
      extU:    imm = {{(`RVD_XLEN-32){ins[31]}}, ins[31:12], 12'b0};
      extS:    imm = {{(`RVD_XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};
      extB:    imm = {{(`RVD_XLEN-13){ins[31]}}, ins[31], ins[7], ins[30:25],
                      ins[11:8], 1'b0};            // bit 0 always zero
      extJ:    imm = {{(`RVD_XLEN-21){ins[31]}}, ins[31], ins[19:12], ins[20],
                      ins[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  creditCounter #(
    .maxCredits (`RVD_OUT_CREDITS)   // consumer buffer depth
  ) outCredits (
    .clk       (clk),
    .rstN      (rstN),
    .spend     (sendNow),
    .refund    (down.credit),
    .available (downAvail)
  );

  assign sendNow    = slotFull && downAvail;
  assign down.valid = sendNow;
  assign down.data  = slotItem;
  assign up.credit  = sendNow;        // returns stage 1's credit

  always_ff @(posedge clk) begin
    if (!rstN) begin
      slotFull <= 1'b0;
    end else begin
      slotFull <= up.valid || (slotFull && !sendNow);
    end
  end

  always_ff @(posedge clk) begin
    if (up.valid) begin
      slotItem <= '{ctrl: up.data.ctrl, imm: imm};
    end
  end

endmodule

/* hw/ctrlDecodeStage.sv */
/*
  Stage 1: RV64I control decode into a one-entry slot.
  Producer may send only with a credit; inCredit pulses when the slot leaves.
  M extension, SYSTEM, unknown opcodes and unused branch/load/store func3
  decode as illegal with all enables cleared.
*/
`timescale 1ns/1ps
`include "rvDecode_cfg.svh"

module ctrlDecodeStage
  import rvDecodePkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 inValid,
  input  logic [`RVD_ILEN-1:0] instr,
  output logic                 inCredit,
  stageLink.tx                 down
);
  localparam ctrlWord_t nopWord = '{
    aluSrcA:  1'b1,
    aluSrcB:  srcBRs2,
    aluOp:    aluAdd,
    extOp:    extR,       // R gives a zero immediate
    branch:   brNone,
    memOp:    memWord,
    memToReg: 1'b0,
    memWen:   1'b0,
    regWen:   1'b0,
    illegal:  1'b0
  };

  opcode_e    opcode;
  logic [2:0] func3;
  logic [6:0] func7;
  logic       bit30;
  logic       isIllegal;
  ctrlWord_t  ctrl;
  logic       slotFull;
  ctrlItem_t  slotItem;
  logic       downAvail;
  logic       sendNow;

  assign opcode = opcode_e'(instr[6:0]);
  assign func3  = instr[14:12];
  assign func7  = instr[31:25];
  assign bit30  = instr[30];       // sub / sra select

  always_comb begin
    ctrl      = nopWord;
    isIllegal = 1'b0;
    case (opcode)
      opLui: begin
        ctrl.aluSrcB = srcBImm; ctrl.aluOp = aluCopyB;
        ctrl.extOp = extU; ctrl.regWen = 1'b1;
      end
      opAuipc: begin
        ctrl.aluSrcA = 1'b0; ctrl.aluSrcB = srcBImm;  // pc + imm
        ctrl.extOp = extU; ctrl.regWen = 1'b1;
      end
      opJal, opJalr: begin
        ctrl.aluSrcA = 1'b0; ctrl.aluSrcB = srcBFour;  // link = pc + 4
        ctrl.extOp  = (opcode == opJal) ? extJ : extI;
        ctrl.branch = (opcode == opJal) ? brJal : brJalr;
        ctrl.regWen = 1'b1;
      end
      opOpImm, opOp: begin
        ctrl.aluSrcB = (opcode == opOp) ? srcBRs2 : srcBImm;
        ctrl.extOp   = (opcode == opOp) ? extR : extI;
        ctrl.regWen  = 1'b1;
        isIllegal    = (opcode == opOp) && (func7 == 7'b0000001);  // mul/div/rem
        case (func3)
          3'b000:  ctrl.aluOp = (opcode == opOp && bit30) ? aluSub : aluAdd;
          3'b001:  ctrl.aluOp = aluSll;
          3'b010:  ctrl.aluOp = aluSlt;
          3'b011:  ctrl.aluOp = aluSltu;
          3'b100:  ctrl.aluOp = aluXor;
          3'b101:  ctrl.aluOp = bit30 ? aluSra : aluSrl;
          3'b110:  ctrl.aluOp = aluOr;
          default: ctrl.aluOp = aluAnd;
        endcase
      end
      opOpImm32, opOp32: begin
        ctrl.aluSrcB = (opcode == opOp32) ? srcBRs2 : srcBImm;
        ctrl.extOp   = (opcode == opOp32) ? extR : extI;
        ctrl.regWen  = 1'b1;
        isIllegal    = (opcode == opOp32) && (func7 == 7'b0000001);  // M word forms
        case (func3)
          3'b000:  ctrl.aluOp = (opcode == opOp32 && bit30) ? aluSubW : aluAddW;
          3'b001:  ctrl.aluOp = aluSllW;
          default: ctrl.aluOp = bit30 ? aluSraW : aluSrlW;  // rest treated as shifts
        endcase
      end
      opBranch: begin
        ctrl.extOp = extB;
        ctrl.aluOp = func3[1] ? aluSltu : aluSlt;  // unsigned compares on 11x
        case (func3)
          3'b000:       ctrl.branch = brEq;
          3'b001:       ctrl.branch = brNe;
          3'b100, 3'b110: ctrl.branch = brLt;
          3'b101, 3'b111: ctrl.branch = brGe;
          default:      isIllegal = 1'b1;
        endcase
      end
      opLoad: begin
        ctrl.aluSrcB = srcBImm; ctrl.extOp = extI;
        ctrl.memToReg = 1'b1; ctrl.regWen = 1'b1;
        case (func3)
          3'b000:  ctrl.memOp = memByte;
          3'b001:  ctrl.memOp = memHalf;
          3'b010:  ctrl.memOp = memWord;
          3'b011:  ctrl.memOp = memDouble;
          3'b100:  ctrl.memOp = memByteU;
          3'b101:  ctrl.memOp = memHalfU;
          3'b110:  ctrl.memOp = memWordU;
          default: isIllegal = 1'b1;   // no ldu
        endcase
      end
      opStore: begin
        ctrl.aluSrcB = srcBImm; ctrl.extOp = extS; ctrl.memWen = 1'b1;
        case (func3)
          3'b000:  ctrl.memOp = memByte;
          3'b001:  ctrl.memOp = memHalf;
          3'b010:  ctrl.memOp = memWord;
          3'b011:  ctrl.memOp = memDouble;
          default: isIllegal = 1'b1;
        endcase
      end
      default: isIllegal = 1'b1;     // SYSTEM and unknown opcodes
    endcase
    if (isIllegal) begin
      ctrl         = nopWord;         // all enables off
      ctrl.illegal = 1'b1;
    end
  end

  creditCounter #(
    .maxCredits (1)                   // stage 2 has one slot
  ) downCredits (
    .clk       (clk),
    .rstN      (rstN),
    .spend     (sendNow),
    .refund    (down.credit),
    .available (downAvail)
  );

  assign sendNow    = slotFull && downAvail;
  assign down.valid = sendNow;
  assign down.data  = slotItem;
  assign inCredit   = sendNow;        // slot frees as it leaves

  always_ff @(posedge clk) begin
    if (!rstN) begin
      slotFull <= 1'b0;
    end else begin
      slotFull <= inValid || (slotFull && !sendNow);
    end
  end

  always_ff @(posedge clk) begin
    if (inValid) begin
      slotItem <= '{instr: instr, ctrl: ctrl};  // payload, no reset
    end
  end

  // producer credit accounting must keep stage 1 from overrun
  assert property (@(posedge clk) disable iff (!rstN) inValid |-> !slotFull)
    else $error("ctrlDecodeStage: instruction arrived while slot was full");

endmodule

/* hw/creditCounter.sv */
/*
  Credits a sender holds toward one receiver.
  Count starts full and never exceeds maxCredits.
  Spend and refund in the same cycle leave the count unchanged.
*/
`timescale 1ns/1ps

module creditCounter #(
  parameter int maxCredits = 1
) (
  input  logic clk,
  input  logic rstN,
  input  logic spend,      // item sent this cycle
  input  logic refund,     // credit returned this cycle
  output logic available
);
  localparam int cntWidth = $clog2(maxCredits + 1);

  logic [cntWidth-1:0] count;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      count <= cntWidth'(maxCredits);  // receiver starts empty
    end else if (spend && !refund) begin
      count <= count - 1'b1;
    end else if (refund && !spend) begin
      count <= count + 1'b1;
    end
  end

  assign available = (count != '0);

  // sender must hold a credit for every item
  assert property (@(posedge clk) disable iff (!rstN) spend |-> count != '0)
    else $error("creditCounter: item sent with no credit left");

  // receiver returned more than it was given
  assert property (@(posedge clk) disable iff (!rstN)
                   refund |-> count != cntWidth'(maxCredits))
    else $error("creditCounter: credit returned while count is full");

endmodule

/* hw/stageLink.sv */
/*
  Credit-based link between two pipeline stages.
  One valid cycle moves one item; one credit pulse frees one slot.
  The sender must track credits itself, the link holds no state.
*/
`timescale 1ns/1ps

interface stageLink #(
  parameter type payload_t = logic
) (
  input logic clk,
  input logic rstN
);
  logic     valid;   // sender has an item this cycle
  payload_t data;
  logic     credit;  // receiver freed one slot

  modport tx (output valid, output data, input credit);
  modport rx (input valid, input data, output credit);

  // link must come out of reset quiet on both directions
  assert property (@(posedge clk) $rose(rstN) |-> !valid && !credit)
    else $error("stageLink: traffic in the first cycle after reset");

endinterface

/* hw/rvDecodePkg.sv */
/*
  Opcode, control-code and payload types for the decoder pipeline.
  Code values match the existing datapath encoding. Do not renumber them.
  M extension and SYSTEM encodings have no entries and decode as illegal.
*/
`include "rvDecode_cfg.svh"

package rvDecodePkg;

  typedef enum logic [6:0] {
    opLoad    = 7'b0000011,
    opOpImm   = 7'b0010011,
    opAuipc   = 7'b0010111,
    opOpImm32 = 7'b0011011,
    opStore   = 7'b0100011,
    opOp      = 7'b0110011,
    opLui     = 7'b0110111,
    opOp32    = 7'b0111011,
    opBranch  = 7'b1100011,
    opJalr    = 7'b1100111,
    opJal     = 7'b1101111
  } opcode_e;

  typedef enum logic [4:0] {
    aluAdd  = 5'd0,  aluSll  = 5'd1,  aluSlt  = 5'd2,  aluSltu = 5'd3,
    aluXor  = 5'd4,  aluSrl  = 5'd5,  aluOr   = 5'd6,  aluAnd  = 5'd7,
    aluSub  = 5'd8,  aluSra  = 5'd13, aluCopyB = 5'd15, // copyB passes operand b
    aluAddW = 5'd16, aluSllW = 5'd17, aluSrlW = 5'd21, aluSubW = 5'd24,
    aluSraW = 5'd29                                     // w forms are base + 16
  } aluOp_e;

  typedef enum logic [1:0] {srcBRs2 = 2'd0, srcBImm = 2'd1, srcBFour = 2'd2} aluSrcB_e;

  typedef enum logic [2:0] {
    extI = 3'd0, extU = 3'd1, extS = 3'd2, extB = 3'd3, extJ = 3'd4, extR = 3'd5
  } extOp_e;

  typedef enum logic [2:0] {
    brNone = 3'd0, brJal = 3'd1, brJalr = 3'd2,
    brEq   = 3'd4, brNe  = 3'd5, brLt   = 3'd6, brGe = 3'd7
  } branch_e;

  typedef enum logic [2:0] {
    memWord  = 3'd0, memByte  = 3'd1, memHalf  = 3'd2, memDouble = 3'd3,
    memWordU = 3'd4, memByteU = 3'd5, memHalfU = 3'd6
  } memOp_e;

  typedef struct packed {
    logic     aluSrcA;  // 0 pc, 1 rs1
    aluSrcB_e aluSrcB;
    aluOp_e   aluOp;
    extOp_e   extOp;
    branch_e  branch;
    memOp_e   memOp;
    logic     memToReg;
    logic     memWen;
    logic     regWen;
    logic     illegal;
  } ctrlWord_t;

  typedef struct packed {
    logic [`RVD_ILEN-1:0] instr;  // kept for stage 2 immediate fields
    ctrlWord_t            ctrl;
  } ctrlItem_t;

  typedef struct packed {
    ctrlWord_t            ctrl;
    logic [`RVD_XLEN-1:0] imm;
  } decodedItem_t;

endpackage

/* hw/rvDecode_cfg.svh */
/*
  Width and credit settings for the RV64I decoder.
  RVD_IN_CREDITS must stay 1 because stage 1 has a single slot.
  RVD_OUT_CREDITS must match the consumer's buffer depth.
*/
`ifndef RVDECODE_CFG_SVH
`define RVDECODE_CFG_SVH

// instruction and data widths
`define RVD_ILEN 32
`define RVD_XLEN 64

// consumer slots granted at reset
`define RVD_OUT_CREDITS 4
// producer credits at reset, one per stage-1 slot
`define RVD_IN_CREDITS 1

`endif
